// ==== hw/nnTypesPkg.sv ====
package nnTypesPkg;

	localparam int FEAT_W = 16;
	localparam int ACC_W = 32;
	localparam int ACT_W = 16;
	localparam int FRAC_BITS = 13; // Q13 fixed point.

	localparam int NUM_FEATURES = 8;
	localparam int NUM_HIDDEN = 4;
	localparam int NEURONS_PER_BANK = 2;
	localparam int NUM_CLASSES = 2;

	typedef logic signed [FEAT_W-1:0] featureT;
	typedef logic signed [FEAT_W-1:0] weightT;
	typedef logic signed [ACC_W-1:0] accT; // Wraps, no saturation.
	typedef logic [ACT_W-1:0] actT;
	typedef logic [$clog2(NUM_FEATURES)-1:0] featIdxT;
	typedef logic [$clog2(NUM_CLASSES)-1:0] classT;

	typedef enum logic [1:0] {L_IDLE, L_ACK, L_WAIT_LOW, L_BUSY} loadStateT;

	typedef enum logic [1:0] {B_IDLE, B_MAC, B_ACT, B_DONE} bankStateT;

	typedef enum logic [2:0] {
		H_WAIT,
		H_MAC,
		H_ACT,
		H_DECIDE,
		H_SEND,
		H_RELEASE
	} headStateT;

	// Negative sums clamp to zero, otherwise keep bits 28 down to 13.
	function automatic actT relu(accT sum);
		if (sum[ACC_W-1])
			return '0;
		return sum[FRAC_BITS+ACT_W-1:FRAC_BITS];
	endfunction

endpackage

// ==== hw/nnWeightsPkg.sv ====
package nnWeightsPkg;

	import nnTypesPkg::*;

	// Hidden weights, one row per hidden neuron, one column per feature.
	localparam weightT HIDDEN_W [NUM_HIDDEN][NUM_FEATURES] = '{
		'{ 2210, -1475,  3902,   618, -2788,  1344,  4071,  -905},
		'{-3316,  2047,  -612,  5120,  1893, -2450,   730,  3368},
		'{ 1502,  3775, -4210, -1189,  2604,   925, -3031,  1777},
		'{-2583,  -842,  2966,  3410, -1120,  4488,  1356, -2219}
	};

	// Biases sit at the product scale, Q26.
	localparam accT HIDDEN_B [NUM_HIDDEN] = '{
		32'sd6553600,
		-32'sd2457600,
		32'sd4915200,
		32'sd1638400
	};

	// Output weights, one row per class, one column per hidden neuron.
	localparam weightT OUT_W [NUM_CLASSES][NUM_HIDDEN] = '{
		'{ 3120, -1840,  2675,  1408},
		'{-1290,  3455,  1985,  2260}
	};

	localparam accT OUT_B [NUM_CLASSES] = '{
		32'sd819200,
		-32'sd409600
	};

endpackage

// ==== hw/bankIf.sv ====
`timescale 1ns/1ps

interface bankIf
	import nnTypesPkg::*;
();

	logic start; // One-cycle pulse.
	featureT feats [NUM_FEATURES];
	actT act [NEURONS_PER_BANK];
	logic done; // Level, held until the next start.

	modport loader (
		output start,
		output feats
	);

	modport bank (
		input start,
		input feats,
		output act,
		output done
	);

	modport head (
		input start,
		input act,
		input done
	);

endinterface

// ==== hw/featureLoader.sv ====
`timescale 1ns/1ps

module featureLoader
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input featureT inData,
	output logic inAck,
	input logic headIdle,
	bankIf.loader bankA,
	bankIf.loader bankB
);

	loadStateT state;
	featIdxT wrIdx;
	featureT featRegs [NUM_FEATURES];
	logic startReg;
	logic lastFeat;

	assign lastFeat = (wrIdx == featIdxT'(NUM_FEATURES - 1));

	// Both banks see the same feature array.
	assign bankA.start = startReg;
	assign bankB.start = startReg;
	assign bankA.feats = featRegs;
	assign bankB.feats = featRegs;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= L_IDLE;
			wrIdx <= '0;
			inAck <= 1'b0;
			startReg <= 1'b0;
		end
		else
		begin
			startReg <= 1'b0;
			case (state)
				L_IDLE:
				begin
					if (inReq)
					begin
						inAck <= 1'b1;
						state <= L_ACK;
					end
				end
				L_ACK, L_WAIT_LOW:
				begin
					if (!inReq)
					begin
						inAck <= 1'b0;
						wrIdx <= wrIdx + 1'b1; // Wraps to 0 after the eighth.
						if (lastFeat)
						begin
							startReg <= 1'b1;
							state <= L_BUSY;
						end
						else
							state <= L_IDLE;
					end
					else
						state <= L_WAIT_LOW;
				end
				L_BUSY:
				begin
					// headIdle is still high while start is out.
					if (headIdle && !startReg)
						state <= L_IDLE;
				end
				default:
					state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == L_IDLE && inReq)
			featRegs[wrIdx] <= inData; // Captured as inAck is raised.
	end

	assert property (@(posedge clk) disable iff (reset) !inReq && !inAck |=> !inAck)
		else $error("inAck rose without inReq");

endmodule

// ==== hw/hiddenBank.sv ====
`timescale 1ns/1ps

module hiddenBank
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
(
	input logic clk,
	input logic reset,
	input logic bankSel,
	bankIf.bank bus
);

	bankStateT state;
	featIdxT macIdx;
	logic [1:0] nBase;
	accT acc [NEURONS_PER_BANK];
	actT actRegs [NEURONS_PER_BANK];
	logic doneReg;

	assign nBase = {bankSel, 1'b0}; // First hidden neuron of this bank.

	assign bus.act = actRegs;
	assign bus.done = doneReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= B_IDLE;
			macIdx <= '0;
			doneReg <= 1'b0;
		end
		else
		begin
			case (state)
				B_MAC:
				begin
					macIdx <= macIdx + 1'b1;
					if (macIdx == featIdxT'(NUM_FEATURES - 1))
						state <= B_ACT;
				end
				B_ACT:
				begin
					doneReg <= 1'b1;
					state <= B_DONE;
				end
				default:
				begin
					// Idle or done, waiting for the loader.
					if (bus.start)
					begin
						macIdx <= '0;
						doneReg <= 1'b0;
						state <= B_MAC;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		for (int k = 0; k < NEURONS_PER_BANK; k++)
		begin
			if (bus.start)
				acc[k] <= HIDDEN_B[nBase + k];
			else if (state == B_MAC)
				acc[k] <= acc[k] + accT'(bus.feats[macIdx])
					* accT'(HIDDEN_W[nBase + k][macIdx]);
			if (state == B_ACT)
				actRegs[k] <= relu(acc[k]);
		end
	end

	assert property (@(posedge clk) disable iff (reset) bus.start |=> !bus.done)
		else $error("done still high after start");

	assert property (@(posedge clk) disable iff (reset) bus.start |-> state != B_MAC)
		else $error("start during MAC");

endmodule

// ==== hw/classifierHead.sv ====
`timescale 1ns/1ps

module classifierHead
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
(
	input logic clk,
	input logic reset,
	bankIf.head bankA,
	bankIf.head bankB,
	output logic headIdle,
	output logic outReq,
	input logic outAck,
	output actT score0,
	output actT score1,
	output classT classId
);

	headStateT state;
	logic pending; // Banks started, results not yet taken.
	logic [$clog2(NUM_HIDDEN)-1:0] hIdx;
	actT hAct;
	accT acc [NUM_CLASSES];

	assign headIdle = (state == H_WAIT) && !pending;

	// Hidden neurons 2 and 3 come from bank B.
	assign hAct = hIdx[1] ? bankB.act[hIdx[0]] : bankA.act[hIdx[0]];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= H_WAIT;
			pending <= 1'b0;
			hIdx <= '0;
			outReq <= 1'b0;
			score0 <= '0;
			score1 <= '0;
			classId <= '0;
		end
		else
		begin
			case (state)
				H_WAIT:
				begin
					if (pending && bankA.done && bankB.done)
					begin
						pending <= 1'b0;
						hIdx <= '0;
						state <= H_MAC;
					end
				end
				H_MAC:
				begin
					hIdx <= hIdx + 1'b1;
					if (hIdx == NUM_HIDDEN - 1)
						state <= H_ACT;
				end
				H_ACT:
				begin
					score0 <= relu(acc[0]);
					score1 <= relu(acc[1]);
					state <= H_DECIDE;
				end
				H_DECIDE:
				begin
					classId <= classT'(score1 > score0); // Ties go to class 0.
					outReq <= 1'b1;
					state <= H_SEND;
				end
				H_SEND:
				begin
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= H_RELEASE;
					end
				end
				H_RELEASE:
				begin
					if (!outAck)
						state <= H_WAIT;
				end
				default:
					state <= H_WAIT;
			endcase
			if (bankA.start)
				pending <= 1'b1; // Both banks start together.
		end
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < NUM_CLASSES; c++)
		begin
			if (state == H_WAIT)
				acc[c] <= OUT_B[c];
			else if (state == H_MAC)
				acc[c] <= acc[c] + accT'(hAct) * accT'(OUT_W[c][hIdx]);
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		outReq && !outAck |=> $stable(score0) && $stable(score1) && $stable(classId))
		else $error("result changed while outReq pending");

endmodule

// ==== hw/neuralLayerTop.sv ====
`timescale 1ns/1ps

module neuralLayerTop
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input featureT inData,
	output logic inAck,
	output logic outReq,
	input logic outAck,
	output actT score0,
	output actT score1,
	output classT classId
);

	logic headIdle;

	bankIf busA ();
	bankIf busB ();

	featureLoader loader (
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inData(inData),
		.inAck(inAck),
		.headIdle(headIdle),
		.bankA(busA.loader),
		.bankB(busB.loader)
	);

	hiddenBank bankA (
		.clk(clk),
		.reset(reset),
		.bankSel(1'b0), // Hidden neurons 0 and 1.
		.bus(busA.bank)
	);

	hiddenBank bankB (
		.clk(clk),
		.reset(reset),
		.bankSel(1'b1), // Hidden neurons 2 and 3.
		.bus(busB.bank)
	);

	classifierHead head (
		.clk(clk),
		.reset(reset),
		.bankA(busA.head),
		.bankB(busB.head),
		.headIdle(headIdle),
		.outReq(outReq),
		.outAck(outAck),
		.score0(score0),
		.score1(score1),
		.classId(classId)
	);

endmodule

// ==== tests/neuralLayerTb.sv ====
`timescale 1ns/1ps

module neuralLayerTb
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
();

	localparam int NUM_TABLE = 6;
	localparam int NUM_VECS = NUM_TABLE + 10;
	localparam int HOLD_VEC = 1; // Result held back for 20 cycles.
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic inReq;
	featureT inData;
	logic inAck;
	logic outReq;
	logic outAck;
	actT score0;
	actT score1;
	classT classId;

	logic [FEAT_W*NUM_FEATURES-1:0] vecs [NUM_VECS]; // Feature 0 in the low bits.
	actT expScore0 [NUM_TABLE];
	actT expScore1 [NUM_TABLE];
	classT expClass [NUM_TABLE];
	int seed;
	logic prevReq;
	logic prevAck;

	neuralLayerTop i_neuralLayerTop (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic reportMismatch(string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		abortRun();
	endtask

	task automatic reportTimeout(string what);
		$display("Timed out at %0t ns while waiting for %s.", $time, what);
		abortRun();
	endtask

	function automatic featureT featureAt(int v, int i);
		return vecs[v][FEAT_W*i +: FEAT_W];
	endfunction

	function automatic accT mulWrap(longint a, longint b);
		return accT'(a * b); // Keep the low 32 bits.
	endfunction

	function automatic actT applyRelu(accT sum);
		if (sum < 0)
			return '0;
		return actT'(sum >>> FRAC_BITS);
	endfunction

	task automatic predict(input int v, output actT s0, output actT s1, output classT c);
		accT sum;
		actT hAct [NUM_HIDDEN];
		actT sc [NUM_CLASSES];
		for (int n = 0; n < NUM_HIDDEN; n++)
		begin
			sum = HIDDEN_B[n];
			for (int i = 0; i < NUM_FEATURES; i++)
				sum = sum + mulWrap(featureAt(v, i), HIDDEN_W[n][i]);
			hAct[n] = applyRelu(sum);
		end
		for (int k = 0; k < NUM_CLASSES; k++)
		begin
			sum = OUT_B[k];
			for (int n = 0; n < NUM_HIDDEN; n++)
				sum = sum + mulWrap(hAct[n], OUT_W[k][n]);
			sc[k] = applyRelu(sum);
		end
		s0 = sc[0];
		s1 = sc[1];
		c = (s1 > s0) ? 1'b1 : 1'b0;
	endtask

	task automatic setRow(int r, logic [FEAT_W*NUM_FEATURES-1:0] f, actT s0, actT s1, classT c);
		vecs[r] = f;
		expScore0[r] = s0;
		expScore1[r] = s1;
		expClass[r] = c;
	endtask

	// Rows are {f7, f6, f5, f4, f3, f2, f1, f0}, then score0, score1, class.
	task automatic loadTable();
		setRow(0, '0, 16'd634, 16'd24, 1'b0);
		setRow(1, {8{16'sd8192}}, 16'd3477, 16'd3685, 1'b1);
		setRow(2, {-16'sd8000, -16'sd8000, -16'sd8000, 16'sd0, 16'sd0, 16'sd0, -16'sd8000,
			16'sd0}, 16'd100, 16'd0, 1'b0); // Every hidden sum negative.
		setRow(3, {-16'sd4420, 16'sd0, -16'sd7857, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0},
			16'd47, 16'd47, 1'b0); // Equal scores.
		setRow(4, {16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd8192, 16'sd0, 16'sd0, 16'sd0},
			16'd177, 16'd2755, 1'b1);
		setRow(5, {16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, -16'sd8192, 16'sd0, 16'sd0},
			16'd1600, 16'd1247, 1'b0);
	endtask

	task automatic waitInAck(logic level);
		int n;
		n = 0;
		while (inAck !== level)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				reportTimeout(level ? "inAck to rise" : "inAck to fall");
		end
	endtask

	task automatic waitOutReq(logic level);
		int n;
		n = 0;
		while (outReq !== level)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				reportTimeout(level ? "outReq to rise" : "outReq to fall");
		end
	endtask

	task automatic sendFeature(featureT value);
		@(negedge clk);
		inData = value;
		inReq = 1'b1;
		waitInAck(1'b1);
		inReq = 1'b0;
		waitInAck(1'b0);
	endtask

	task automatic runInference(int v, int firstIdx, logic holdResult);
		actT s0;
		actT s1;
		classT c;
		for (int i = firstIdx; i < NUM_FEATURES; i++)
			sendFeature(featureAt(v, i));
		waitOutReq(1'b1);
		predict(v, s0, s1, c);
		if (v < NUM_TABLE)
			assert (s0 == expScore0[v] && s1 == expScore1[v] && c == expClass[v])
				else reportMismatch($sformatf("model disagrees with table row %0d", v));
		assert (score0 === s0 && score1 === s1 && classId === c)
			else reportMismatch($sformatf(
				"vector %0d gave %0d %0d class %0d, expected %0d %0d class %0d",
				v, score0, score1, classId, s0, s1, c));
		if (holdResult)
		begin
			@(negedge clk);
			inData = featureAt(v + 1, 0); // Early request for the next vector.
			inReq = 1'b1;
			repeat (20)
			begin
				@(negedge clk);
				assert (outReq && !inAck && score0 === s0 && score1 === s1 && classId === c)
					else reportMismatch("result or inAck changed while outAck was held low");
			end
		end
		@(negedge clk);
		outAck = 1'b1;
		waitOutReq(1'b0);
		if (holdResult)
		begin
			// The result handshake is not over until outAck falls.
			repeat (3)
			begin
				@(negedge clk);
				assert (!inAck) else reportMismatch("inAck rose before outAck fell");
			end
		end
		outAck = 1'b0;
		if (holdResult)
		begin
			waitInAck(1'b1);
			inReq = 1'b0;
			waitInAck(1'b0);
		end
	endtask

	// Four-phase rule on the input side, sampled before the DUT updates.
	always @(posedge clk)
	begin
		if (!reset)
		begin
			assert (!(inAck && !prevAck) || prevReq)
				else reportMismatch("inAck rose while inReq was low");
			assert (!(!inAck && prevAck) || !prevReq)
				else reportMismatch("inAck fell before inReq fell");
		end
		prevReq <= inReq;
		prevAck <= inAck;
	end

	initial
	begin
		seed = 32'h4a3d113c;
		reset = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		loadTable();
		for (int v = NUM_TABLE; v < NUM_VECS; v++)
			vecs[v] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!inAck && !outReq && score0 === '0 && score1 === '0 && classId === '0)
			else reportMismatch("outputs not cleared by reset");
		for (int v = 0; v < NUM_VECS; v++)
			runInference(v, (v == HOLD_VEC + 1) ? 1 : 0, v == HOLD_VEC);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== sources.f ====
hw/nnTypesPkg.sv
hw/nnWeightsPkg.sv
hw/bankIf.sv
hw/featureLoader.sv
hw/hiddenBank.sv
hw/classifierHead.sv
hw/neuralLayerTop.sv
tests/neuralLayerTb.sv
